/* compile.f */
cpuPkg.sv
alu.sv
registerFile.sv
controlUnit.sv
datapath.sv
cpuTop.sv
tbClock.sv
cpuTop_sva.sv
cpuTb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - cpuPkg.sv
  - alu.sv
  - registerFile.sv
  - controlUnit.sv
  - datapath.sv
  - cpuTop.sv
  - target: test
    files:
      - tbClock.sv
      - cpuTop_sva.sv
      - cpuTb.sv

/* cpuTb.sv */
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int progLength    = 75;
    localparam int maxDelay      = 3;
    localparam int clkPeriod     = 4;
    localparam int timeoutCycles = 40 * progLength * maxDelay;

    logic clk;
    logic rstN;
    logic readM;
    logic writeM;
    logic halted;
    wordT address;
    wordT writeData;
    wordT readData;
    logic inputReady;
    logic ackOutput;

    wordT   mem [256];
    wordT   logAddr [$];
    wordT   logData [$];
    wordT   expAddr [$];
    wordT   expData [$];
    integer seed;
    int     waitLeft;
    logic   pulseSent;
    int     testsRun;
    int     testsFailed;

    tbClock u_tbClock (
        .clk  (clk),
        .rstN (rstN)
    );

    cpuTop #(
        .resetVector (16'h0000)
    ) u_cpuTop (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .halted     (halted)
    );

    function automatic wordT encodeImm(opcodeT op, regAddrT rs, regAddrT rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encodeReg(regAddrT rs, regAddrT rt, regAddrT rd, funcT fn);
        return {RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic wordT encodeJump(opcodeT op, logic [11:0] target);
        return {op, target};
    endfunction

    function automatic void expectStore(wordT addr, wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endfunction

    // Preset r2 to the taken marker, let the fall-through path overwrite it, then store.
    task automatic loadBranchCase(input int base, input wordT branchInstr, input int k);
        mem[base]     = encodeImm(ADI, 2'd0, 2'd2, 8'(8'h40 + k));
        mem[base + 1] = branchInstr;
        mem[base + 2] = encodeImm(ADI, 2'd0, 2'd2, 8'(8'h60 + k));
        mem[base + 3] = encodeImm(SWD, 2'd0, 2'd2, 8'(8'hB0 + k));
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~8'(i), 8'(i)};
        end
        mem[8'h80] = 16'h5A3C;
        mem[8'h81] = 16'h8421;
        mem[8'h82] = 16'hBEEF;
        // Every odd word from 3 to 25 stores r2 to the next slot at 16'hFFA0.
        for (int n = 0; n < 12; n++) begin
            mem[3 + 2 * n] = encodeImm(SWD, 2'd0, 2'd2, 8'(8'hA0 + n));
        end
        mem[0]  = encodeImm(LWD, 2'd0, 2'd1, 8'h80);
        mem[1]  = encodeImm(LWD, 2'd0, 2'd3, 8'h81);
        mem[2]  = encodeReg(2'd1, 2'd3, 2'd2, ADD);
        mem[4]  = encodeReg(2'd1, 2'd3, 2'd2, SUB);
        mem[6]  = encodeReg(2'd1, 2'd3, 2'd2, AND);
        mem[8]  = encodeReg(2'd1, 2'd3, 2'd2, ORR);
        mem[10] = encodeReg(2'd1, 2'd0, 2'd2, NOT);
        mem[12] = encodeReg(2'd1, 2'd0, 2'd2, TCP);
        mem[14] = encodeReg(2'd1, 2'd0, 2'd2, SHL);
        mem[16] = encodeReg(2'd3, 2'd0, 2'd2, SHR);
        mem[18] = encodeImm(ADI, 2'd1, 2'd2, 8'h85);
        mem[20] = encodeImm(ORI, 2'd1, 2'd2, 8'h43);
        mem[22] = encodeImm(LHI, 2'd0, 2'd2, 8'hC7);
        mem[24] = encodeImm(LWD, 2'd0, 2'd2, 8'h82);
        loadBranchCase(26, encodeImm(BNE, 2'd1, 2'd3, 8'h01), 0);
        loadBranchCase(30, encodeImm(BNE, 2'd1, 2'd1, 8'h01), 1);
        loadBranchCase(34, encodeImm(BEQ, 2'd1, 2'd1, 8'h01), 2);
        loadBranchCase(38, encodeImm(BEQ, 2'd1, 2'd3, 8'h01), 3);
        loadBranchCase(42, encodeImm(BGZ, 2'd1, 2'd0, 8'h01), 4);
        loadBranchCase(46, encodeImm(BGZ, 2'd0, 2'd0, 8'h01), 5);
        loadBranchCase(50, encodeImm(BLZ, 2'd3, 2'd0, 8'h01), 6);
        loadBranchCase(54, encodeImm(BLZ, 2'd1, 2'd0, 8'h01), 7);
        mem[58] = encodeImm(ADI, 2'd0, 2'd2, 8'h50);
        mem[59] = encodeJump(JMP, 12'd61);
        mem[60] = encodeImm(ADI, 2'd0, 2'd2, 8'h70);
        mem[61] = encodeImm(SWD, 2'd0, 2'd2, 8'hB8);
        mem[62] = encodeJump(JAL, 12'd64);
        mem[63] = encodeImm(ADI, 2'd0, 2'd2, 8'h71);
        mem[64] = encodeImm(SWD, 2'd0, 2'd2, 8'hB9);
        mem[65] = encodeImm(ADI, 2'd0, 2'd3, 8'd69);
        mem[66] = encodeImm(ADI, 2'd0, 2'd2, 8'h52);
        mem[67] = encodeReg(2'd3, 2'd0, 2'd0, JPR);
        mem[68] = encodeImm(ADI, 2'd0, 2'd2, 8'h72);
        mem[69] = encodeImm(SWD, 2'd0, 2'd2, 8'hBA);
        mem[70] = encodeImm(ADI, 2'd0, 2'd3, 8'd73);
        mem[71] = encodeReg(2'd3, 2'd0, 2'd0, JRL);
        mem[72] = encodeImm(ADI, 2'd0, 2'd2, 8'h73);
        mem[73] = encodeImm(SWD, 2'd0, 2'd2, 8'hBB);
        mem[74] = encodeReg(2'd0, 2'd0, 2'd0, HLT);
    endtask

    task automatic loadExpected();
        // Operands are r1 = 16'h5A3C and r3 = 16'h8421; SHR works on r3.
        expectStore(16'hFFA0, 16'hDE5D);
        expectStore(16'hFFA1, 16'hD61B);
        expectStore(16'hFFA2, 16'h0020);
        expectStore(16'hFFA3, 16'hDE3D);
        expectStore(16'hFFA4, 16'hA5C3);
        expectStore(16'hFFA5, 16'hA5C4);
        expectStore(16'hFFA6, 16'hB478);
        expectStore(16'hFFA7, 16'hC210);
        // ADI adds the sign-extended 8'h85, ORI ors in 8'h43, LHI puts 8'hC7 on top.
        expectStore(16'hFFA8, 16'h59C1);
        expectStore(16'hFFA9, 16'h5A7F);
        expectStore(16'hFFAA, 16'hC700);
        expectStore(16'hFFAB, 16'hBEEF);
        // Even cases are taken and keep 8'h40 + case, odd ones fall through to 8'h60 + case.
        expectStore(16'hFFB0, 16'h0040);
        expectStore(16'hFFB1, 16'h0061);
        expectStore(16'hFFB2, 16'h0042);
        expectStore(16'hFFB3, 16'h0063);
        expectStore(16'hFFB4, 16'h0044);
        expectStore(16'hFFB5, 16'h0065);
        expectStore(16'hFFB6, 16'h0046);
        expectStore(16'hFFB7, 16'h0067);
        expectStore(16'hFFB8, 16'h0050);
        expectStore(16'hFFB9, 16'h003F);   // JAL sits at 62.
        expectStore(16'hFFBA, 16'h0052);
        expectStore(16'hFFBB, 16'h0048);   // JRL sits at 71.
    endtask

    task automatic finishTest(input string name, input logic ok);
        testsRun++;
        if (ok) begin
            $display("%-22s ok", name);
        end else begin
            $display("%-22s FAILED", name);
            testsFailed++;
        end
    endtask

    task automatic checkStores(input string name, input int first, input int count);
        int bad;
        bad = 0;
        for (int i = first; i < first + count; i++) begin
            if (i >= logData.size()) begin
                $display("%s: store number %0d never happened", name, i);
                bad++;
            end else begin
                assert (logAddr[i] == expAddr[i]) else begin
                    $display("CHECK FAILED %s: store %0d address expected %h actual %h",
                             name, i, expAddr[i], logAddr[i]);
                    bad++;
                end
                assert (logData[i] == expData[i]) else begin
                    $display("CHECK FAILED %s: store %0d data expected %h actual %h",
                             name, i, expData[i], logData[i]);
                    bad++;
                end
            end
        end
        finishTest(name, bad == 0);
    endtask

    task automatic checkStoreCount();
        logic ok;
        ok = 1'b1;
        assert (logData.size() == expData.size()) else begin
            $display("CHECK FAILED store count: expected %0d actual %0d",
                     expData.size(), logData.size());
            ok = 1'b0;
        end
        finishTest("store count", ok);
    endtask

    task automatic reportAssertions(input string name, input int errors);
        if (errors != 0) begin
            $display("%s: %0d assertion failures were reported", name, errors);
        end
        finishTest(name, errors == 0);
    endtask

    // Memory model answering each request after 0 to maxDelay cycles.
    always @(negedge clk) begin
        inputReady <= 1'b0;
        ackOutput  <= 1'b0;
        if (!rstN || pulseSent) begin
            pulseSent = 1'b0;
            waitLeft  = -1;
        end else if (readM || writeM) begin
            if (waitLeft < 0) begin
                waitLeft = $unsigned($random(seed)) % (maxDelay + 1);
            end
            if (waitLeft == 0) begin
                if (readM) begin
                    readData   <= mem[address[7:0]];
                    inputReady <= 1'b1;
                end else begin
                    mem[address[7:0]] = writeData;
                    logAddr.push_back(address);
                    logData.push_back(writeData);
                    ackOutput <= 1'b1;
                end
                pulseSent = 1'b1;
                waitLeft  = -1;
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: the processor did not halt within %0d cycles.", timeoutCycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed        = 28;
        waitLeft    = -1;
        pulseSent   = 1'b0;
        testsRun    = 0;
        testsFailed = 0;
        readData    = '0;
        inputReady  = 1'b0;
        ackOutput   = 1'b0;
        loadProgram();
        loadExpected();
        wait (rstN === 1'b1);
        do begin
            @(negedge clk);
        end while (halted !== 1'b1);
        // A quiet stretch lets the halt assertion watch the parked core.
        repeat (20) @(posedge clk);
        checkStores("register arithmetic", 0, 8);
        checkStores("immediate forms", 8, 3);
        checkStores("memory round trip", 11, 1);
        checkStores("branches and jumps", 12, 12);
        checkStoreCount();
        reportAssertions("reset and handshake", u_cpuTop.u_cpuTopSva.handshakeErrors);
        reportAssertions("halt", u_cpuTop.u_cpuTopSva.haltErrors);
        $display("Summary: %0d tests run, %0d failing", testsRun, testsFailed);
        if (testsFailed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpuTop_sva.sv */
`default_nettype none

module cpuTopSva import cpuPkg::*; (
    input wire       clk,
    input wire       rstN,
    input wire       readM,
    input wire       writeM,
    input wire wordT address,
    input wire wordT writeData,
    input wire       inputReady,
    input wire       ackOutput,
    input wire       halted
);

    int handshakeErrors = 0;
    int haltErrors = 0;

    // Every cycle after a reset edge starts with an idle bus.
    resetIdle: assert property (@(posedge clk) !rstN |=> !readM && !writeM && !halted)
        else begin
            $error("memory bus not idle after reset");
            handshakeErrors++;
        end

    noReadWrite: assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
        else begin
            $error("read and write requested together");
            handshakeErrors++;
        end

    readHold: assert property (@(posedge clk) disable iff (!rstN)
        readM && !inputReady |=> readM && $stable(address))
        else begin
            $error("read request dropped or address moved before ready");
            handshakeErrors++;
        end

    writeHold: assert property (@(posedge clk) disable iff (!rstN)
        writeM && !ackOutput |=> writeM && $stable(address) && $stable(writeData))
        else begin
            $error("write request dropped or changed before ack");
            handshakeErrors++;
        end

    readDrop: assert property (@(posedge clk) disable iff (!rstN)
        readM && inputReady |=> !readM)
        else begin
            $error("read request still high after ready");
            handshakeErrors++;
        end

    writeDrop: assert property (@(posedge clk) disable iff (!rstN)
        writeM && ackOutput |=> !writeM)
        else begin
            $error("write request still high after ack");
            handshakeErrors++;
        end

    // Once halted the core stays parked and leaves the bus alone.
    haltParked: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted && !readM && !writeM)
        else begin
            $error("activity after halt");
            haltErrors++;
        end

endmodule

bind cpuTop cpuTopSva u_cpuTopSva (
    .clk        (clk),
    .rstN       (rstN),
    .readM      (readM),
    .writeM     (writeM),
    .address    (address),
    .writeData  (writeData),
    .inputReady (inputReady),
    .ackOutput  (ackOutput),
    .halted     (halted)
);

`default_nettype wire

/* tbClock.sv */
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod  = 2;
    localparam int resetCycles = 16;

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        // Release on a falling edge like every other DUT input.
        @(negedge clk);
        rstN = 1'b1;
    end

    always #halfPeriod clk = ~clk;

endmodule

`default_nettype wire

/* cpuTop.sv */
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter wordT resetVector = '0
) (
    input  wire       clk,
    input  wire       rstN,
    output logic      readM,
    output logic      writeM,
    output wordT      address,
    output wordT      writeData,
    input  wire wordT readData,
    input  wire       inputReady,
    input  wire       ackOutput,
    output logic      halted
);

    opcodeT     opcode;
    funcT       func;
    logic       jump;
    branchCondT branchCond;
    logic       memToReg;
    logic       memRead;
    logic       memWrite;
    logic       regDst;
    logic       regWrite;
    aluOpT      aluOp;
    logic       aluSrc;
    logic       linkPc;
    logic       jumpReg;
    logic       loadHigh;
    logic       halt;

    controlUnit u_controlUnit (
        .opcode     (opcode),
        .func       (func),
        .jump       (jump),
        .branchCond (branchCond),
        .memToReg   (memToReg),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .regDst     (regDst),
        .regWrite   (regWrite),
        .aluOp      (aluOp),
        .aluSrc     (aluSrc),
        .linkPc     (linkPc),
        .jumpReg    (jumpReg),
        .loadHigh   (loadHigh),
        .halt       (halt)
    );

    datapath #(
        .resetVector (resetVector)
    ) u_datapath (
        .clk        (clk),
        .rstN       (rstN),
        .readData   (readData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .jump       (jump),
        .branchCond (branchCond),
        .memToReg   (memToReg),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .regDst     (regDst),
        .regWrite   (regWrite),
        .aluOp      (aluOp),
        .aluSrc     (aluSrc),
        .linkPc     (linkPc),
        .jumpReg    (jumpReg),
        .loadHigh   (loadHigh),
        .halt       (halt),
        .opcode     (opcode),
        .func       (func),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .halted     (halted)
    );

endmodule

`default_nettype wire

/* datapath.sv */
`default_nettype none

module datapath import cpuPkg::*; #(
    parameter wordT resetVector = '0
) (
    input  wire             clk,
    input  wire             rstN,
    input  wire wordT       readData,
    input  wire             inputReady,
    input  wire             ackOutput,
    input  wire             jump,
    input  wire branchCondT branchCond,
    input  wire             memToReg,
    input  wire             memRead,
    input  wire             memWrite,
    input  wire             regDst,
    input  wire             regWrite,
    input  wire aluOpT      aluOp,
    input  wire             aluSrc,
    input  wire             linkPc,
    input  wire             jumpReg,
    input  wire             loadHigh,
    input  wire             halt,
    output opcodeT          opcode,
    output funcT            func,
    output logic            readM,
    output logic            writeM,
    output wordT            address,
    output wordT            writeData,
    output logic            halted
);

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stExecute,
        stMemory,
        stWriteback,
        stHalted
    } stateT;

    stateT   state;
    wordT    pc;
    wordT    pcPlusOne;
    wordT    pcNext;
    wordT    instrReg;
    wordT    aluResultQ;
    wordT    loadedData;
    logic    branchTaken;
    logic    takenNow;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    regAddrT writeReg;
    wordT    immExt;
    wordT    operandA;
    wordT    operandB;
    wordT    aluResult;
    wordT    readDataA;
    wordT    readDataB;
    wordT    regWriteData;

    assign opcode    = opcodeT'(instrReg[15:12]);
    assign func      = funcT'(instrReg[5:0]);
    assign rs        = instrReg[11:10];
    assign rt        = instrReg[9:8];
    assign rd        = instrReg[7:6];
    assign immExt    = {{8{instrReg[7]}}, instrReg[7:0]};
    assign pcPlusOne = pc + 16'd1;

    // Branches add the offset to PC+1, everything else works on rs.
    assign operandA = (branchCond != brNone) ? pcPlusOne : readDataA;
    assign operandB = aluSrc ? immExt : readDataB;
    assign writeReg = linkPc ? linkReg : (regDst ? rd : rt);

    always_comb begin
        if (memToReg) begin
            regWriteData = loadedData;
        end else if (linkPc) begin
            regWriteData = pcPlusOne;
        end else if (loadHigh) begin
            regWriteData = {instrReg[7:0], 8'h00};
        end else begin
            regWriteData = aluResultQ;
        end
    end

    registerFile u_registerFile (
        .clk         (clk),
        .rstN        (rstN),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .writeAddr   (writeReg),
        .writeData   (regWriteData),
        .writeEnable (regWrite && (state == stWriteback)),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

    alu u_alu (
        .operandA (operandA),
        .operandB (operandB),
        .aluOp    (aluOp),
        .result   (aluResult),
        .overflow ()
    );

    always_comb begin
        case (branchCond)
            brNotEqual:    takenNow = readDataA != readDataB;
            brEqual:       takenNow = readDataA == readDataB;
            brGreaterZero: takenNow = $signed(readDataA) > 16'sd0;
            brLessZero:    takenNow = $signed(readDataA) < 16'sd0;
            default:       takenNow = 1'b0;
        endcase
    end

    always_comb begin
        if (jumpReg) begin
            pcNext = readDataA;
        end else if (jump) begin
            pcNext = {pc[15:12], instrReg[11:0]};
        end else if (branchTaken) begin
            pcNext = aluResultQ;
        end else begin
            pcNext = pcPlusOne;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            pc    <= resetVector;
        end else begin
            case (state)
                stIdle: state <= stFetch;
                stFetch: begin
                    if (inputReady) begin
                        state <= stExecute;
                    end
                end
                stExecute: state <= (memRead || memWrite) ? stMemory : stWriteback;
                stMemory: begin
                    if ((memRead && inputReady) || (memWrite && ackOutput)) begin
                        state <= stWriteback;
                    end
                end
                stWriteback: begin
                    pc    <= pcNext;
                    state <= halt ? stHalted : stFetch;
                end
                default: state <= stHalted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch && inputReady) begin
            instrReg <= readData;
        end
        if (state == stExecute) begin
            aluResultQ  <= aluResult;
            branchTaken <= takenNow;
        end
        if (state == stMemory && memRead && inputReady) begin
            loadedData <= readData;
        end
    end

    // Requests are plain levels held for as long as the state waits.
    assign readM     = (state == stFetch) || ((state == stMemory) && memRead);
    assign writeM    = (state == stMemory) && memWrite;
    assign address   = (state == stFetch) ? pc : aluResultQ;
    assign writeData = readDataB;
    assign halted    = state == stHalted;

endmodule

`default_nettype wire

/* controlUnit.sv */
`default_nettype none

module controlUnit import cpuPkg::*; (
    input  wire opcodeT opcode,
    input  wire funcT   func,
    output logic        jump,
    output branchCondT  branchCond,
    output logic        memToReg,
    output logic        memRead,
    output logic        memWrite,
    output logic        regDst,
    output logic        regWrite,
    output aluOpT       aluOp,
    output logic        aluSrc,
    output logic        linkPc,
    output logic        jumpReg,
    output logic        loadHigh,
    output logic        halt
);

    always_comb begin
        // Anything not listed below falls through as a no-op.
        jump       = 1'b0;
        branchCond = brNone;
        memToReg   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        regDst     = 1'b0;
        regWrite   = 1'b0;
        aluOp      = aluAdd;
        aluSrc     = 1'b0;
        linkPc     = 1'b0;
        jumpReg    = 1'b0;
        loadHigh   = 1'b0;
        halt       = 1'b0;
        case (opcode)
            BNE: begin
                branchCond = brNotEqual;
                aluSrc     = 1'b1;
            end
            BEQ: begin
                branchCond = brEqual;
                aluSrc     = 1'b1;
            end
            BGZ: begin
                branchCond = brGreaterZero;
                aluSrc     = 1'b1;
            end
            BLZ: begin
                branchCond = brLessZero;
                aluSrc     = 1'b1;
            end
            ADI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            ORI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOr;
            end
            LHI: begin
                regWrite = 1'b1;
                loadHigh = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluPassB;
            end
            LWD: begin
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            SWD: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            JMP: jump = 1'b1;
            JAL: begin
                jump     = 1'b1;
                linkPc   = 1'b1;
                regWrite = 1'b1;
            end
            RTYPE: begin
                case (func)
                    ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR: begin
                        regWrite = 1'b1;
                        regDst   = 1'b1;
                    end
                    JPR: jumpReg = 1'b1;
                    JRL: begin
                        jumpReg  = 1'b1;
                        linkPc   = 1'b1;
                        regWrite = 1'b1;
                    end
                    HLT: halt = 1'b1;
                    default: ;
                endcase
                case (func)
                    SUB:     aluOp = aluSub;
                    AND:     aluOp = aluAnd;
                    ORR:     aluOp = aluOr;
                    NOT:     aluOp = aluNot;
                    TCP:     aluOp = aluTcp;
                    SHL:     aluOp = aluShl;
                    SHR:     aluOp = aluShr;
                    default: aluOp = aluAdd;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* registerFile.sv */
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire          clk,
    input  wire          rstN,
    input  wire regAddrT readAddrA,
    input  wire regAddrT readAddrB,
    input  wire regAddrT writeAddr,
    input  wire wordT    writeData,
    input  wire          writeEnable,
    output wordT         readDataA,
    output wordT         readDataB
);

    wordT regs [4];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            foreach (regs[i]) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Reads see the old value during a write cycle.
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu import cpuPkg::*; (
    input  wire wordT  operandA,
    input  wire wordT  operandB,
    input  wire aluOpT aluOp,
    output wordT       result,
    output logic       overflow
);

    wordT sum;
    wordT diff;

    assign sum  = operandA + operandB;
    assign diff = operandA - operandB;

    always_comb begin
        result   = operandB;
        overflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                result   = sum;
                overflow = (operandA[15] == operandB[15]) && (sum[15] != operandA[15]);
            end
            aluSub: begin
                result   = diff;
                overflow = (operandA[15] != operandB[15]) && (diff[15] != operandA[15]);
            end
            aluAnd:   result = operandA & operandB;
            aluOr:    result = operandA | operandB;
            aluNot:   result = ~operandA;
            aluTcp:   result = ~operandA + 16'd1;
            aluShl:   result = {operandA[14:0], 1'b0};
            // Arithmetic shift keeps the sign bit.
            aluShr:   result = {operandA[15], operandA[15:1]};
            aluPassB: result = operandB;
            default:  result = operandB;
        endcase
    end

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0] regAddrT;

    // Major opcode in instruction bits 15:12.
    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        JAL   = 4'd10,
        RTYPE = 4'd15
    } opcodeT;

    // Function field in bits 5:0, only meaningful for RTYPE.
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        JRL = 6'd26,
        HLT = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluNot,
        aluTcp,
        aluShl,
        aluShr,
        aluPassB
    } aluOpT;

    typedef enum logic [2:0] {
        brNone,
        brNotEqual,
        brEqual,
        brGreaterZero,
        brLessZero
    } branchCondT;

    // JAL and JRL leave the return address here.
    localparam regAddrT linkReg = 2'd2;

endpackage

`default_nettype wire
